// ==== tb.f ====
+incdir+logic
logic/mem_req_pkg.sv
logic/flush_pkg.sv
logic/l1_req_arbiter.sv
logic/req_queue.sv
logic/wb_mem_master.sv
logic/flush_sequencer.sv
logic/cache_complex.sv
bench/cache_complex_asserts.sv
bench/cache_complex_tb.sv

// ==== Bender.yml ====
package:
  name: cache_complex

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mem_req_pkg.sv
      - logic/flush_pkg.sv
      - logic/l1_req_arbiter.sv
      - logic/req_queue.sv
      - logic/wb_mem_master.sv
      - logic/flush_sequencer.sv
      - logic/cache_complex.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - bench/cache_complex_asserts.sv
      - bench/cache_complex_tb.sv

// ==== bench/cache_complex_tb.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_complex_tb;

   import mem_req_pkg::*;

   localparam int N_STIM         = 33;
   localparam int N_GROUPS       = 9;
   localparam int BP_GROUP       = 5;  // slow memory, queue fills
   localparam int FIRST_FLUSH    = 6;
   localparam int TIMEOUT_CYCLES = N_STIM * 40 + 400;
   localparam logic [31:0] FILL_KEY = 32'h5a5a0000;

   typedef struct {
      int          grp;
      req_src_t    src;
      mem_op_t     op;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [31:0] exp;
   } stim_t;

   stim_t stim [N_STIM] = '{
      '{0, src_instr, op_load,  32'h0000_0040, 32'h0, 32'h0},
      '{0, src_instr, op_load,  32'h0000_1044, 32'h0, 32'h0},
      '{0, src_instr, op_load,  32'h00a0_0008, 32'h0, 32'h0},
      '{1, src_data,  op_load,  32'h2000_0010, 32'h0, 32'h0},
      '{1, src_data,  op_load,  32'h2000_0014, 32'h0, 32'h0},
      '{1, src_data,  op_load,  32'hdead_0000, 32'h0, 32'h0},
      '{2, src_data,  op_store, 32'h3000_0000, 32'h1234_5678, 32'h0},
      '{2, src_data,  op_store, 32'h3000_0004, 32'hcafe_f00d, 32'h0},
      '{3, src_instr, op_load,  32'h3000_0000, 32'h0, 32'h0},
      '{3, src_data,  op_load,  32'h3000_0000, 32'h0, 32'h0},
      '{3, src_data,  op_load,  32'h3000_0004, 32'h0, 32'h0},
      '{4, src_instr, op_load,  32'h0000_0400, 32'h0, 32'h0},
      '{4, src_instr, op_load,  32'h0000_0404, 32'h0, 32'h0},
      '{4, src_instr, op_load,  32'h0000_0408, 32'h0, 32'h0},
      '{4, src_instr, op_load,  32'h0000_040c, 32'h0, 32'h0},
      '{4, src_data,  op_store, 32'h0000_0500, 32'ha5a5_0001, 32'h0},
      '{4, src_data,  op_load,  32'h0000_0500, 32'h0, 32'h0},
      '{4, src_data,  op_load,  32'h0000_0504, 32'h0, 32'h0},
      '{4, src_data,  op_store, 32'h0000_0508, 32'h0f0f_0f0f, 32'h0},
      '{5, src_instr, op_load,  32'h0000_0600, 32'h0, 32'h0},
      '{5, src_instr, op_load,  32'h0000_0604, 32'h0, 32'h0},
      '{5, src_instr, op_load,  32'h0000_0608, 32'h0, 32'h0},
      '{5, src_data,  op_load,  32'h0000_0700, 32'h0, 32'h0},
      '{5, src_data,  op_load,  32'h0000_0704, 32'h0, 32'h0},
      '{5, src_data,  op_store, 32'h0000_0708, 32'h7777_0708, 32'h0},
      '{5, src_data,  op_load,  32'h0000_0708, 32'h0, 32'h0},
      '{6, src_instr, op_load,  32'h0000_0800, 32'h0, 32'h0},
      '{6, src_data,  op_load,  32'h0000_0900, 32'h0, 32'h0},
      '{6, src_data,  op_store, 32'h0000_0904, 32'h0bad_0904, 32'h0},
      '{7, src_instr, op_load,  32'h0000_0810, 32'h0, 32'h0},
      '{7, src_data,  op_load,  32'h0000_0910, 32'h0, 32'h0},
      '{8, src_data,  op_load,  32'h0000_0920, 32'h0, 32'h0},
      '{8, src_instr, op_load,  32'h0000_0820, 32'h0, 32'h0}
   };

   logic                   clk;
   logic                   reset;
   logic                   l1i_req_valid;
   logic [`ADDR_WIDTH-1:0] l1i_addr;
   logic                   l1i_req_ack;
   logic                   l1i_rsp_valid;
   logic [`DATA_WIDTH-1:0] l1i_rsp_data;
   logic                   l1d_req_valid;
   logic [`ADDR_WIDTH-1:0] l1d_addr;
   mem_op_t                l1d_op;
   logic [`DATA_WIDTH-1:0] l1d_wdata;
   logic                   l1d_req_ack;
   logic                   l1d_rsp_valid;
   logic [`DATA_WIDTH-1:0] l1d_rsp_data;
   logic                   wb_cyc;
   logic                   wb_stb;
   logic                   wb_we;
   logic [`ADDR_WIDTH-1:0] wb_adr;
   logic [`DATA_WIDTH-1:0] wb_dat_o;
   logic                   wb_ack = 1'b0;
   logic [`DATA_WIDTH-1:0] wb_dat_i = '0;
   logic                   l1i_flush_req;
   logic                   l1d_flush_req;
   logic                   l1i_flush_complete;
   logic                   l1d_flush_complete;
   logic                   in_flush_mode;
   logic                   flush_done;

   logic [31:0] mem [logic [31:0]];
   logic [31:0] lfsr = 32'h929d;
   int          extra_wait = 0;
   int          wait_left = 0;
   logic        mem_busy = 1'b0;
   int          pend_i [$];
   int          pend_d [$];
   int          cur_idx_i = 0;
   int          cur_idx_d = 0;
   int          ack_count = 0;
   int          ack_base = 0;
   int          rsp_count = 0;
   int          flush_done_count = 0;
   int          cycle_count = 0;
   int          value_errs = 0;
   int          proto_errs = 0;
   logic        have_last = 1'b0;
   logic        last_src_d = 1'b0;
   logic        saw_full = 1'b0;
   logic        prev_flush_mode = 1'b0;

   cache_complex u_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return addr ^ FILL_KEY;
   endfunction

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output int val);
      int b;
      val = 0;
      for (b = 0; b < n; b++)
      begin
         lfsr = lfsr_step(lfsr);
         val  = (val << 1) | int'(lfsr[0]);
      end
   endtask

   // walk the table in order, stores update the model
   function automatic void compute_expected();
      logic [31:0] model [logic [31:0]];
      int k;
      for (k = 0; k < N_STIM; k++)
      begin
         if (stim[k].op == op_store)
         begin
            model[stim[k].addr] = stim[k].wdata;
            stim[k].exp = '0;
         end
         else if (model.exists(stim[k].addr))
            stim[k].exp = model[stim[k].addr];
         else
            stim[k].exp = fill_word(stim[k].addr);
      end
   endfunction

   // wishbone slave, 0..3 waits plus extra_wait
   always @(negedge clk)
   begin
      if (reset)
      begin
         wb_ack   = 1'b0;
         mem_busy = 1'b0;
      end
      else if (wb_ack)
         wb_ack = 1'b0;
      else if (wb_cyc && wb_stb)
      begin
         if (!mem_busy)
         begin
            mem_busy = 1'b1;
            take_bits(2, wait_left);
            wait_left = wait_left + extra_wait;
         end
         if (wait_left == 0)
         begin
            if (wb_we)
               mem[wb_adr] = wb_dat_o;
            else
               wb_dat_i = mem.exists(wb_adr) ? mem[wb_adr] : fill_word(wb_adr);
            wb_ack   = 1'b1;
            mem_busy = 1'b0;
         end
         else
            wait_left--;
      end
   end

   task automatic check_rsp(input req_src_t src, input logic [31:0] data);
      int idx;
      idx = -1;
      if (src == src_instr && pend_i.size() != 0)
         idx = pend_i.pop_front();
      else if (src == src_data && pend_d.size() != 0)
         idx = pend_d.pop_front();
      assert (idx >= 0)
      else
      begin
         $display("response on the %s port with no request pending", src.name());
         proto_errs++;
      end
      if (idx >= 0 && stim[idx].op == op_load)
      begin
         assert (data === stim[idx].exp)
         else
         begin
            $display("[FAIL] %s: got %h, expected %h (addr %h)",
                     (src == src_instr) ? "l1i_rsp_data" : "l1d_rsp_data",
                     data, stim[idx].exp, stim[idx].addr);
            value_errs++;
         end
      end
      rsp_count++;
   endtask

   always @(posedge clk)
   begin
      if (!reset)
      begin
         // acks of this cycle already fall outside flush mode
         if (flush_done)
         begin
            flush_done_count++;
            assert (prev_flush_mode && !in_flush_mode)
            else
            begin
               $display("in_flush_mode did not fall together with flush_done");
               proto_errs++;
            end
            assert (pend_i.size() + pend_d.size() == 0)
            else
            begin
               $display("queued requests still pending at flush_done");
               proto_errs++;
            end
         end
         if (l1i_req_ack || l1d_req_ack)
         begin
            assert (!(l1i_req_ack && l1d_req_ack))
            else
            begin
               $display("both ports acked in the same cycle");
               proto_errs++;
            end
            assert (!in_flush_mode)
            else
            begin
               $display("request acked during flush mode");
               proto_errs++;
            end
            assert (!u_dut.full)
            else
            begin
               $display("request acked while the queue was full");
               proto_errs++;
            end
            if (l1i_req_valid && l1d_req_valid && have_last)
            begin
               // port not granted last wins the tie
               assert (l1i_req_ack == last_src_d)
               else
               begin
                  $display("[FAIL] l1i_req_ack: got %h, expected %h", l1i_req_ack, last_src_d);
                  value_errs++;
               end
            end
            have_last  = 1'b1;
            last_src_d = l1d_req_ack;
            if (l1i_req_ack)
               pend_i.push_back(cur_idx_i);
            if (l1d_req_ack)
               pend_d.push_back(cur_idx_d);
            ack_count++;
         end
         if (l1i_rsp_valid)
            check_rsp(src_instr, l1i_rsp_data);
         if (l1d_rsp_valid)
            check_rsp(src_data, l1d_rsp_data);
         if (u_dut.full)
            saw_full = 1'b1;
         prev_flush_mode = in_flush_mode;
      end
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES)
      begin
         $display("timeout after %0d cycles, the run did not finish", cycle_count);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic wait_ack(input req_src_t src);
      logic got;
      got = 1'b0;
      while (!got)
      begin
         @(posedge clk);
         got = (src == src_instr) ? l1i_req_ack : l1d_req_ack;
      end
   endtask

   // hold each request until acked, back to back
   task automatic issue_port(input req_src_t src, input int grp);
      int k;
      for (k = 0; k < N_STIM; k++)
      begin
         if (stim[k].grp == grp && stim[k].src == src)
         begin
            @(negedge clk);
            if (src == src_instr)
            begin
               l1i_req_valid = 1'b1;
               l1i_addr      = stim[k].addr;
               cur_idx_i     = k;
            end
            else
            begin
               l1d_req_valid = 1'b1;
               l1d_addr      = stim[k].addr;
               l1d_op        = stim[k].op;
               l1d_wdata     = stim[k].wdata;
               cur_idx_d     = k;
            end
            wait_ack(src);
         end
      end
      @(negedge clk);
      if (src == src_instr)
         l1i_req_valid = 1'b0;
      else
         l1d_req_valid = 1'b0;
   endtask

   task automatic pulse_complete(input logic instr_side);
      @(negedge clk);
      l1i_flush_complete = instr_side;
      l1d_flush_complete = !instr_side;
      @(negedge clk);
      l1i_flush_complete = 1'b0;
      l1d_flush_complete = 1'b0;
   endtask

   // 6: both, instr done first  7: both, data first  8: data cache only
   task automatic run_flush(input int grp);
      int done_base;
      done_base = flush_done_count;
      while (ack_count == ack_base)
         @(negedge clk);
      l1d_flush_req = 1'b1;
      l1i_flush_req = (grp != 8);
      @(negedge clk);
      l1i_flush_req = 1'b0;
      l1d_flush_req = 1'b0;
      @(posedge clk);
      assert (in_flush_mode === 1'b1)
      else
      begin
         $display("[FAIL] in_flush_mode: got %h, expected %h", in_flush_mode, 1'b1);
         value_errs++;
      end
      repeat (3) @(negedge clk);
      pulse_complete(grp == 6);
      repeat (2) @(negedge clk);
      if (grp != 8)
         pulse_complete(grp != 6);
      while (flush_done_count == done_base)
         @(posedge clk);
      repeat (3) @(posedge clk);
      assert (flush_done_count == done_base + 1)
      else
      begin
         $display("flush_done pulsed more than once for one flush");
         proto_errs++;
      end
   endtask

   task automatic run_group(input int grp);
      int k;
      int target;
      int rsp_base;
      target = 0;
      for (k = 0; k < N_STIM; k++)
         if (stim[k].grp == grp)
            target++;
      rsp_base   = rsp_count;
      ack_base   = ack_count;
      saw_full   = 1'b0;
      extra_wait = (grp >= BP_GROUP) ? 6 : 0;
      fork
         issue_port(src_instr, grp);
         issue_port(src_data, grp);
         if (grp >= FIRST_FLUSH)
            run_flush(grp);
      join
      while (rsp_count - rsp_base < target)
         @(posedge clk);
      if (grp == BP_GROUP)
      begin
         assert (saw_full)
         else
         begin
            $display("request queue never filled under slow memory");
            proto_errs++;
         end
      end
      extra_wait = 0;
   endtask

   initial
   begin
      int g;
      compute_expected();
      reset              = 1'b1;
      l1i_req_valid      = 1'b0;
      l1i_addr           = '0;
      l1d_req_valid      = 1'b0;
      l1d_addr           = '0;
      l1d_op             = op_load;
      l1d_wdata          = '0;
      l1i_flush_req      = 1'b0;
      l1d_flush_req      = 1'b0;
      l1i_flush_complete = 1'b0;
      l1d_flush_complete = 1'b0;
      repeat (16) @(posedge clk);
      assert (!l1i_req_ack && !l1d_req_ack && !l1i_rsp_valid && !l1d_rsp_valid && !wb_cyc &&
              !wb_stb && !in_flush_mode && !u_dut.drain_req && !flush_done)
      else
      begin
         $display("outputs not low while in reset");
         proto_errs++;
      end
      @(negedge clk);
      reset = 1'b0;
      for (g = 0; g < N_GROUPS; g++)
         run_group(g);
      repeat (10) @(posedge clk); // catch stray responses
      $display("run complete: %0d value errors, %0d protocol errors", value_errs, proto_errs);
      if (value_errs + proto_errs == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// ==== bench/cache_complex_asserts.sv ====
`timescale 1ns/1ps

module cache_complex_asserts
(
   input logic                     clk,
   input logic                     reset,
   input logic                     wb_cyc,
   input logic                     wb_stb,
   input logic                     wb_ack,
   input flush_pkg::flush_state_t  seq_state,
   input logic                     drain_req,
   input logic                     in_flush_mode
);

   import flush_pkg::*;

   a_stb_with_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
      else $error("wb_stb high without wb_cyc");

   a_cyc_until_ack: assert property (@(posedge clk) disable iff (reset)
      wb_cyc && !wb_ack |=> wb_cyc)
      else $error("wb_cyc dropped before wb_ack");

   // single beat, bus released right after ack
   a_cyc_ends: assert property (@(posedge clk) disable iff (reset)
      wb_cyc && wb_ack |=> !wb_cyc)
      else $error("wb_cyc still high after wb_ack");

   a_drain_state: assert property (@(posedge clk) disable iff (reset)
      drain_req |-> seq_state == flush_drain)
      else $error("drain_req high outside the drain state");

   a_idle_mode: assert property (@(posedge clk) disable iff (reset)
      seq_state == flush_idle |-> !in_flush_mode)
      else $error("in_flush_mode high in the idle state");

endmodule

bind wb_mem_master cache_complex_asserts u_wb_asserts (
   .clk           (clk),
   .reset         (reset),
   .wb_cyc        (wb_cyc),
   .wb_stb        (wb_stb),
   .wb_ack        (wb_ack),
   .seq_state     (flush_pkg::flush_idle),
   .drain_req     (1'b0),
   .in_flush_mode (1'b0)
);

bind flush_sequencer cache_complex_asserts u_flush_asserts (
   .clk           (clk),
   .reset         (reset),
   .wb_cyc        (1'b0),
   .wb_stb        (1'b0),
   .wb_ack        (1'b0),
   .seq_state     (state),
   .drain_req     (drain_req),
   .in_flush_mode (in_flush_mode)
);

// ==== logic/cache_complex.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_complex
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    l1i_req_valid,
   input  logic [`ADDR_WIDTH-1:0]  l1i_addr,
   output logic                    l1i_req_ack,
   output logic                    l1i_rsp_valid,
   output logic [`DATA_WIDTH-1:0]  l1i_rsp_data,
   input  logic                    l1d_req_valid,
   input  logic [`ADDR_WIDTH-1:0]  l1d_addr,
   input  mem_req_pkg::mem_op_t    l1d_op,
   input  logic [`DATA_WIDTH-1:0]  l1d_wdata,
   output logic                    l1d_req_ack,
   output logic                    l1d_rsp_valid,
   output logic [`DATA_WIDTH-1:0]  l1d_rsp_data,
   output logic                    wb_cyc,
   output logic                    wb_stb,
   output logic                    wb_we,
   output logic [`ADDR_WIDTH-1:0]  wb_adr,
   output logic [`DATA_WIDTH-1:0]  wb_dat_o,
   input  logic                    wb_ack,
   input  logic [`DATA_WIDTH-1:0]  wb_dat_i,
   input  logic                    l1i_flush_req,
   input  logic                    l1d_flush_req,
   input  logic                    l1i_flush_complete,
   input  logic                    l1d_flush_complete,
   output logic                    in_flush_mode,
   output logic                    flush_done
);

   import mem_req_pkg::*;

   mem_req_t push_data;
   mem_req_t head_data;
   logic     push;
   logic     pop;
   logic     full;
   logic     empty;
   logic     drain_req;
   logic     drain_done;

   l1_req_arbiter u_arbiter (
      .clk           (clk),
      .reset         (reset),
      .in_flush_mode (in_flush_mode),
      .l1i_req_valid (l1i_req_valid),
      .l1i_addr      (l1i_addr),
      .l1d_req_valid (l1d_req_valid),
      .l1d_addr      (l1d_addr),
      .l1d_op        (l1d_op),
      .l1d_wdata     (l1d_wdata),
      .full          (full),
      .l1i_req_ack   (l1i_req_ack),
      .l1d_req_ack   (l1d_req_ack),
      .push          (push),
      .push_data     (push_data)
   );

   req_queue u_queue (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .head_data (head_data),
      .full      (full),
      .empty     (empty)
   );

   wb_mem_master u_master (
      .clk           (clk),
      .reset         (reset),
      .empty         (empty),
      .head_data     (head_data),
      .drain_req     (drain_req),
      .wb_ack        (wb_ack),
      .wb_dat_i      (wb_dat_i),
      .pop           (pop),
      .wb_cyc        (wb_cyc),
      .wb_stb        (wb_stb),
      .wb_we         (wb_we),
      .wb_adr        (wb_adr),
      .wb_dat_o      (wb_dat_o),
      .l1i_rsp_valid (l1i_rsp_valid),
      .l1i_rsp_data  (l1i_rsp_data),
      .l1d_rsp_valid (l1d_rsp_valid),
      .l1d_rsp_data  (l1d_rsp_data),
      .drain_done    (drain_done)
   );

   // blocks the arbiter while both L1s flush
   flush_sequencer u_flush_seq (
      .clk                (clk),
      .reset              (reset),
      .l1i_flush_req      (l1i_flush_req),
      .l1d_flush_req      (l1d_flush_req),
      .l1i_flush_complete (l1i_flush_complete),
      .l1d_flush_complete (l1d_flush_complete),
      .drain_done         (drain_done),
      .in_flush_mode      (in_flush_mode),
      .drain_req          (drain_req),
      .flush_done         (flush_done)
   );

endmodule

// ==== logic/flush_sequencer.sv ====
`timescale 1ns/1ps

module flush_sequencer
(
   input  logic clk,
   input  logic reset,
   input  logic l1i_flush_req,
   input  logic l1d_flush_req,
   input  logic l1i_flush_complete,
   input  logic l1d_flush_complete,
   input  logic drain_done,
   output logic in_flush_mode,
   output logic drain_req,
   output logic flush_done
);

   import flush_pkg::*;

   flush_state_t state;
   flush_state_t next_state;

   always_comb
   begin
      next_state = state;
      case (state)
         flush_idle:
         begin
            if (l1i_flush_req && l1d_flush_req)
               next_state = flush_wait_both;
            else if (l1i_flush_req)
               next_state = flush_got_data; // data side not flushing
            else if (l1d_flush_req)
               next_state = flush_got_instr;
         end
         flush_wait_both:
         begin
            if (l1i_flush_complete && l1d_flush_complete)
               next_state = flush_drain;
            else if (l1d_flush_complete)
               next_state = flush_got_data;
            else if (l1i_flush_complete)
               next_state = flush_got_instr;
         end
         flush_got_data:
         begin
            if (l1i_flush_complete)
               next_state = flush_drain;
         end
         flush_got_instr:
         begin
            if (l1d_flush_complete)
               next_state = flush_drain;
         end
         flush_drain:
         begin
            if (drain_done)
               next_state = flush_idle;
         end
         default:
            next_state = flush_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= flush_idle;
         in_flush_mode <= 1'b0;
         flush_done    <= 1'b0;
      end
      else
      begin
         state         <= next_state;
         in_flush_mode <= (next_state != flush_idle);
         flush_done    <= (state == flush_drain) && drain_done; // same edge mode drops
      end
   end

   assign drain_req = (state == flush_drain);

endmodule

// ==== logic/wb_mem_master.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module wb_mem_master
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    empty,
   input  mem_req_pkg::mem_req_t   head_data,
   input  logic                    drain_req,
   input  logic                    wb_ack,
   input  logic [`DATA_WIDTH-1:0]  wb_dat_i,
   output logic                    pop,
   output logic                    wb_cyc,
   output logic                    wb_stb,
   output logic                    wb_we,
   output logic [`ADDR_WIDTH-1:0]  wb_adr,
   output logic [`DATA_WIDTH-1:0]  wb_dat_o,
   output logic                    l1i_rsp_valid,
   output logic [`DATA_WIDTH-1:0]  l1i_rsp_data,
   output logic                    l1d_rsp_valid,
   output logic [`DATA_WIDTH-1:0]  l1d_rsp_data,
   output logic                    drain_done
);

   import mem_req_pkg::*;

   typedef enum logic [1:0] {
      st_idle = 2'd0,
      st_bus  = 2'd1,
      st_resp = 2'd2
   } mst_state_t;

   mst_state_t             state;
   mem_req_t               cur_req;  // request on the bus
   logic [`DATA_WIDTH-1:0] rdata;

   assign pop = (state == st_idle) && !empty;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= st_idle;
      else
      begin
         case (state)
            st_idle:
               if (!empty)
                  state <= st_bus;
            st_bus:
               if (wb_ack)
                  state <= st_resp;
            st_resp:
               state <= st_idle;
            default:
               state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (pop)
         cur_req <= head_data;
      if (state == st_bus && wb_ack)
         rdata <= wb_dat_i;
   end

   // classic cycle, one beat
   assign wb_cyc   = (state == st_bus);
   assign wb_stb   = (state == st_bus);
   assign wb_we    = (cur_req.op == op_store);
   assign wb_adr   = cur_req.addr;
   assign wb_dat_o = cur_req.wdata;

   assign l1i_rsp_valid = (state == st_resp) && (cur_req.src == src_instr);
   assign l1d_rsp_valid = (state == st_resp) && (cur_req.src == src_data);
   assign l1i_rsp_data  = rdata;
   assign l1d_rsp_data  = rdata; // stale for stores

   // nothing queued, nothing in flight
   assign drain_done = drain_req && empty && (state == st_idle);

endmodule

// ==== logic/req_queue.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module req_queue
#(
   parameter int DEPTH = `REQ_Q_DEPTH
)
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   push,
   input  mem_req_pkg::mem_req_t  push_data,
   input  logic                   pop,
   output mem_req_pkg::mem_req_t  head_data,
   output logic                   full,
   output logic                   empty
);

   import mem_req_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   mem_req_t           slots [DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;
   logic               do_push;
   logic               do_pop;

   assign do_push = push && !full;   // overflow dropped
   assign do_pop  = pop && !empty;

   always_ff @(posedge clk)
   begin
      if (do_push)
         slots[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      end
   end

   assign head_data = slots[rd_ptr];
   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);

endmodule

// ==== logic/l1_req_arbiter.sv ====
`timescale 1ns/1ps
`include "cache_defs.svh"

module l1_req_arbiter
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    in_flush_mode,
   input  logic                    l1i_req_valid,
   input  logic [`ADDR_WIDTH-1:0]  l1i_addr,
   input  logic                    l1d_req_valid,
   input  logic [`ADDR_WIDTH-1:0]  l1d_addr,
   input  mem_req_pkg::mem_op_t    l1d_op,
   input  logic [`DATA_WIDTH-1:0]  l1d_wdata,
   input  logic                    full,
   output logic                    l1i_req_ack,
   output logic                    l1d_req_ack,
   output logic                    push,
   output mem_req_pkg::mem_req_t   push_data
);

   import mem_req_pkg::*;

   req_src_t last_grant;
   logic     grant_i;
   logic     grant_d;
   logic     accept; // queue can take a request this cycle

   assign accept = !full && !in_flush_mode;

   always_comb
   begin
      if (l1i_req_valid && l1d_req_valid)
      begin
         // loser of the last round goes first
         grant_i = (last_grant == src_data);
         grant_d = (last_grant == src_instr);
      end
      else
      begin
         grant_i = l1i_req_valid;
         grant_d = l1d_req_valid;
      end
   end

   assign l1i_req_ack = grant_i && accept;
   assign l1d_req_ack = grant_d && accept;
   assign push = l1i_req_ack || l1d_req_ack;

   always_comb
   begin
      if (l1d_req_ack)
         push_data = '{addr: l1d_addr, wdata: l1d_wdata, op: l1d_op, src: src_data};
      else
         push_data = '{addr: l1i_addr, wdata: '0, op: op_load, src: src_instr}; // fetch only reads
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         last_grant <= src_data; // instr side wins the first tie
      else if (push)
         last_grant <= l1d_req_ack ? src_data : src_instr;
   end

endmodule

// ==== logic/flush_pkg.sv ====
package flush_pkg;

   typedef enum logic [2:0] {
      flush_idle      = 3'd0,
      flush_wait_both = 3'd1,
      flush_got_data  = 3'd2, // data side done, waiting on instr
      flush_got_instr = 3'd3,
      flush_drain     = 3'd4
   } flush_state_t;

endpackage

// ==== logic/mem_req_pkg.sv ====
`include "cache_defs.svh"

package mem_req_pkg;

   typedef enum logic {
      op_load  = 1'b0,
      op_store = 1'b1
   } mem_op_t;

   typedef enum logic {
      src_instr = 1'b0,
      src_data  = 1'b1
   } req_src_t;

   // 66 bits, addr in the top bits
   typedef struct packed {
      logic [`ADDR_WIDTH-1:0] addr;
      logic [`DATA_WIDTH-1:0] wdata;
      mem_op_t                op;
      req_src_t               src; // routes the response back
   } mem_req_t;

endpackage

// ==== logic/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address into external memory
`define ADDR_WIDTH 32

// one access moves one word
`define DATA_WIDTH 32

// pending requests between arbiter and bus master
`define REQ_Q_DEPTH 4

`endif
